/* build.f */
logic/ecc_dsa_pkg.sv
logic/ecc_dsa_sequencer.sv
logic/ecc_dsa_ctrl.sv
logic/ecc_dsa_regfile.sv
logic/ecc_dsa_top.sv
verification/tb_ecc_dsa.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run from the project root, then judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ecc_dsa \
  -f build.f -o tb_ecc_dsa > build.log 2>&1 \
  && ./obj_dir/tb_ecc_dsa > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "^SIMULATION PASSED$" sim.log \
  && { echo "simulation result: pass"; exit 0; } \
  || { echo "simulation result: fail, see sim.log"; exit 1; }

/* verification/ecc_dsa_patterns.txt */
# job msg privkey scalar_g pubkey_x pubkey_y r s | model: qx qy sign_r sign_s ver_g ver_pk
# job 0 keygen, 1 sign, 2 verify; every column in hex
0 1f3a5c7e 2b4d6f81 0c0ffee1 a1b2c3 d4e5f6 135791 246802 5ad1e0f3 6be2f104 7cf30215 8d041326 9e1524 af2635
1 c001d00d 0badf00d 600dcafe 112233 445566 778899 aabbcc 01234567 89abcdef fedcba98 76543210 13579b 2468ac
2 deadbeef 00000000 12345678 9abcde f01234 56789a bcdef0 0f1e2d3c 4b5a6978 87a6b5c4 d3e2f1a0 3c5d7e 8f9a0b
1 ffffffff 7fffffff 80000001 000001 000002 000003 000004 55aa55aa aa55aa55 5a5a5a5a a5a5a5a5 000005 000006
0 00000001 ffffffff 80000000 abcdef 123456 654321 fedcba 11111111 22222222 33333333 44444444 555555 666666
2 31415926 53589793 23846264 338327 950288 419716 939937 51058209 74944592 30781640 62862089 986280 348253
2 a5a50000 5a5a0000 00ff00ff ff00ff 0f0f0f f0f0f0 3c3c3c 77777777 88888888 99999999 aaaaaaaa bbbbbb cccccc
1 27182818 28459045 23536028 747135 266249 775724 709369 99595749 66967627 72407663 03535475 945713 821785
0 0000ffff ffff0000 1248edb7 369cf2 48d159 5ae26a 6cf37b 7d048c 8e159d 9f26ae b037bf c148d0 d259e1
2 feedface cafebabe 8badf00d 0ddba1 1deb17 b01dfa ce5eed 00c0ffee ba5eba11 f00dbabe deadc0de 1ee7c0 de5a17

/* verification/tb_ecc_dsa.sv */
`timescale 1ns/1ns

module tb_ecc_dsa;
  import ecc_dsa_pkg::*;

  // One pattern line, host operands then core model results
  typedef struct packed {
    dsa_job_t job;
    data_t    msg, priv, sg, pkx, pky, r, s;
    data_t    qx, qy, sr, ss, vg, vpk;
  } pattern_t;

  logic        clka = 1'b0;
  logic        rst_n;
  logic        host_wr;
  reg_id_t     host_wr_id, host_rd_id;
  data_t       host_wr_data, host_rd_data;
  logic        job_start;
  dsa_job_t    job;
  logic        busy, done;
  logic        core_wr, core_rd, core_scalar_wr, core_cmd_valid;
  opr_addr_t   core_wr_addr, core_rd_addr;
  data_t       core_wr_data, core_scalar;
  data_t       core_rd_data = '0;
  dsa_opcode_t core_cmd;
  logic        core_busy = 1'b0;

  pattern_t patterns [$];
  pattern_t cur;
  data_t    core_mem [256];
  data_t    cmd_q [$];
  data_t    scalar_q [$];
  integer   seed = 32'h68d9_97f5;
  int       busy_cnt;
  int       done_cnt = 0;
  int       errors = 0;
  int       checks = 0;
  bit       loaded = 1'b0;

  always #5 clka = ~clka;

  ecc_dsa_top dut0 (.*);

  // --------------------------------------------------------------------------
  // Core model
  // --------------------------------------------------------------------------
  always @(posedge clka) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        core_mem[i] = 32'ha5a5_0000 ^ i;
      end
      busy_cnt  <= 0;
      core_busy <= 1'b0;
    end else begin
      if (core_wr) begin
        core_mem[core_wr_addr] = core_wr_data;
      end
      if (core_rd) begin
        core_rd_data <= core_mem[core_rd_addr];
      end
      if (core_scalar_wr) begin
        scalar_q.push_back(core_scalar);
      end
      if (core_cmd_valid) begin
        cmd_q.push_back(data_t'(core_cmd));
        core_busy <= 1'b1;
        busy_cnt  <= ($random(seed) & 15) + 1;
      end else if (busy_cnt > 0) begin
        busy_cnt <= busy_cnt - 1;
        // Results appear as busy drops
        if (busy_cnt == 1) begin
          core_busy <= 1'b0;
          core_mem[UOP_OPR_Qx_AFFN]   = cur.qx;
          core_mem[UOP_OPR_Qy_AFFN]   = cur.qy;
          core_mem[UOP_OPR_SIGN_R]    = cur.sr;
          core_mem[UOP_OPR_SIGN_S]    = cur.ss;
          core_mem[UOP_OPR_SCALAR_G]  = cur.vg;
          core_mem[UOP_OPR_SCALAR_PK] = cur.vpk;
        end
      end
    end
  end

  always @(posedge clka) begin
    if (rst_n && done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_queue(input string name, input data_t got [$], input data_t exp [$]);
    check_value({name, " count"}, data_t'(got.size()), data_t'(exp.size()));
    for (int i = 0; i < exp.size() && i < got.size(); i++) begin
      check_value($sformatf("%s[%0d]", name, i), got[i], exp[i]);
    end
  endtask

  task automatic write_reg(input reg_id_t id, input data_t val);
    @(posedge clka);
    host_wr      <= 1'b1;
    host_wr_id   <= id;
    host_wr_data <= val;
    @(posedge clka);
    host_wr <= 1'b0;
  endtask

  task automatic check_reg(input string name, input reg_id_t id, input data_t exp);
    @(posedge clka);
    host_rd_id <= id;
    @(negedge clka);
    check_value(name, host_rd_data, exp);
  endtask

  task automatic wait_done();
    do begin
      @(negedge clka);
    end while (done !== 1'b1);
  endtask

  task automatic wait_core_busy();
    do begin
      @(negedge clka);
    end while (core_busy !== 1'b1);
  endtask

  task automatic load_patterns();
    int       fd;
    string    line;
    data_t    f [14];
    pattern_t p;
    fd = $fopen("verification/ecc_dsa_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                  f[7], f[8], f[9], f[10], f[11], f[12], f[13]) == 14) begin
        p = {f[0][1:0], f[1], f[2], f[3], f[4], f[5], f[6],
             f[7], f[8], f[9], f[10], f[11], f[12], f[13]};
        patterns.push_back(p);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_job(input int n, input pattern_t p);
    int    errs_before;
    int    dones_before;
    data_t exp_cmds [$];
    data_t exp_scalars [$];
    errs_before = errors;
    write_reg(MSG_ID, p.msg);
    write_reg(PRIVKEY_ID, p.priv);
    write_reg(SCALAR_G_ID, p.sg);
    write_reg(PUBKEYX_ID, p.pkx);
    write_reg(PUBKEYY_ID, p.pky);
    write_reg(R_ID, p.r);
    write_reg(S_ID, p.s);
    cmd_q.delete();
    scalar_q.delete();
    cur = p;
    dones_before = done_cnt;
    @(posedge clka);
    job_start <= 1'b1;
    job       <= p.job;
    @(posedge clka);
    // Start held a second cycle plus a host write, both while busy
    host_wr      <= 1'b1;
    host_wr_id   <= MSG_ID;
    host_wr_data <= ~p.msg;
    @(posedge clka);
    job_start <= 1'b0;
    host_wr   <= 1'b0;
    // Another start pulse while the core is working
    wait_core_busy();
    @(posedge clka);
    job_start <= 1'b1;
    @(posedge clka);
    job_start <= 1'b0;
    wait_done();
    repeat (20) @(negedge clka);
    check_value("done pulses", data_t'(done_cnt - dones_before), 32'd1);
    check_value("busy", data_t'(busy), '0);
    check_reg("MSG", MSG_ID, p.msg);
    case (p.job)
      JOB_KEYGEN: begin
        exp_cmds.push_back(data_t'(DSA_UOP_KEYGEN));
        exp_scalars.push_back(p.sg);
        check_reg("PUBKEYX", PUBKEYX_ID, p.qx);
        check_reg("PUBKEYY", PUBKEYY_ID, p.qy);
      end
      JOB_SIGN: begin
        exp_cmds.push_back(data_t'(DSA_UOP_SIGN));
        exp_scalars.push_back(p.sg);
        check_value("core_mem[HASH_MSG]", core_mem[UOP_OPR_HASH_MSG], p.msg);
        check_value("core_mem[PRIVKEY]", core_mem[UOP_OPR_PRIVKEY], p.priv);
        check_reg("R", R_ID, p.sr);
        check_reg("S", S_ID, p.ss);
      end
      default: begin
        exp_cmds.push_back(data_t'(DSA_UOP_VERIFY0));
        exp_cmds.push_back(data_t'(DSA_UOP_VERIFY1));
        exp_cmds.push_back(data_t'(DSA_UOP_VERIFY2));
        exp_scalars.push_back(p.vg);
        exp_scalars.push_back(p.vpk);
        check_reg("R_VERIFY", R_VERIFY_ID, p.qx);
      end
    endcase
    check_queue("cmd", cmd_q, exp_cmds);
    check_queue("scalar", scalar_q, exp_scalars);
    $display("test %0d job %0d finished, %0d errors", n, p.job, errors - errs_before);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    rst_n        <= 1'b0;
    host_wr      <= 1'b0;
    host_wr_id   <= NOP_ID;
    host_wr_data <= '0;
    host_rd_id   <= NOP_ID;
    job_start    <= 1'b0;
    job          <= JOB_KEYGEN;
    load_patterns();
    loaded = 1'b1;
    repeat (4) @(posedge clka);
    rst_n <= 1'b1;
    // Init program runs by itself
    @(negedge clka);
    check_value("busy", data_t'(busy), 32'd1);
    wait_done();
    check_value("busy", data_t'(busy), '0);
    check_value("core_mem[CONST_ZERO]", core_mem[UOP_OPR_CONST_ZERO], CONST_ZERO_VAL);
    check_value("core_mem[CONST_ONE]", core_mem[UOP_OPR_CONST_ONE], CONST_ONE_VAL);
    check_value("core_mem[CONST_E_a]", core_mem[UOP_OPR_CONST_E_a], CONST_E_a_MONT_VAL);
    check_value("core_mem[CONST_ONE_MONT]", core_mem[UOP_OPR_CONST_ONE_MONT],
                CONST_ONE_p_MONT_VAL);
    check_value("core_mem[CONST_R2_p]", core_mem[UOP_OPR_CONST_R2_p], CONST_R2_p_MONT_VAL);
    check_value("core_mem[CONST_GX]", core_mem[UOP_OPR_CONST_GX_MONT], CONST_G_X_MONT_VAL);
    check_value("core_mem[CONST_GY]", core_mem[UOP_OPR_CONST_GY_MONT], CONST_G_Y_MONT_VAL);
    check_value("core_mem[CONST_GZ]", core_mem[UOP_OPR_CONST_GZ_MONT], CONST_G_Z_MONT_VAL);
    check_value("core_mem[CONST_R2_q]", core_mem[UOP_OPR_CONST_R2_q], CONST_R2_q_MONT_VAL);
    check_value("core_mem[CONST_ONE_q]", core_mem[UOP_OPR_CONST_ONE_q_MONT],
                CONST_ONE_q_MONT_VAL);
    $display("test 0 init finished, %0d errors", errors);
    if (patterns.size() == 0) begin
      errors++;
      $display("no test patterns were loaded");
    end
    foreach (patterns[i]) begin
      run_job(i + 1, patterns[i]);
    end
    $display("%0d tests, %0d checks, %0d errors", patterns.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat ((patterns.size() + 1) * 2000) @(posedge clka);
    $display("timeout: the run did not finish within its cycle budget");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* logic/ecc_dsa_top.sv */
`timescale 1ns/1ns

module ecc_dsa_top (
  input  logic                     clka,
  input  logic                     rst_n,
  // Host side
  input  logic                     host_wr,
  input  ecc_dsa_pkg::reg_id_t     host_wr_id,
  input  ecc_dsa_pkg::data_t       host_wr_data,
  input  ecc_dsa_pkg::reg_id_t     host_rd_id,
  output ecc_dsa_pkg::data_t       host_rd_data,
  input  logic                     job_start,
  input  ecc_dsa_pkg::dsa_job_t    job,
  output logic                     busy,
  output logic                     done,
  // Point-multiplication core
  output logic                     core_wr,
  output ecc_dsa_pkg::opr_addr_t   core_wr_addr,
  output ecc_dsa_pkg::data_t       core_wr_data,
  output logic                     core_rd,
  output ecc_dsa_pkg::opr_addr_t   core_rd_addr,
  input  ecc_dsa_pkg::data_t       core_rd_data,
  output logic                     core_scalar_wr,
  output ecc_dsa_pkg::data_t       core_scalar,
  output logic                     core_cmd_valid,
  output ecc_dsa_pkg::dsa_opcode_t core_cmd,
  input  logic                     core_busy
);
  import ecc_dsa_pkg::*;

  prog_addr_t prog_addr;
  dsa_uop_t   uop;
  reg_id_t    rf_rd_id;
  data_t      rf_rd_data;
  logic       rf_wr;
  reg_id_t    rf_wr_id;
  data_t      rf_wr_data;

  // --------------------------------------------------------------------------
  // Controller, micro-op ROM and register bank
  // --------------------------------------------------------------------------
  ecc_dsa_ctrl ctrl0 (.*);

  ecc_dsa_sequencer seq0 (
    .clka      (clka),
    .prog_addr (prog_addr),
    .uop       (uop)
  );

  ecc_dsa_regfile rf0 (.*);

endmodule

/* logic/ecc_dsa_regfile.sv */
`timescale 1ns/1ns

module ecc_dsa_regfile (
  input  logic                 clka,
  input  logic                 rst_n,
  input  logic                 host_wr,
  input  ecc_dsa_pkg::reg_id_t host_wr_id,
  input  ecc_dsa_pkg::data_t   host_wr_data,
  input  ecc_dsa_pkg::reg_id_t host_rd_id,
  output ecc_dsa_pkg::data_t   host_rd_data,
  input  logic                 rf_wr,
  input  ecc_dsa_pkg::reg_id_t rf_wr_id,
  input  ecc_dsa_pkg::data_t   rf_wr_data,
  input  ecc_dsa_pkg::reg_id_t rf_rd_id,
  output ecc_dsa_pkg::data_t   rf_rd_data,
  input  logic                 busy
);
  import ecc_dsa_pkg::*;

  data_t regs [NUM_REGS];

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      regs[CONST_ZERO_ID]       <= CONST_ZERO_VAL;
      regs[CONST_ONE_ID]        <= CONST_ONE_VAL;
      regs[CONST_E_a_MONT_ID]   <= CONST_E_a_MONT_VAL;
      regs[CONST_ONE_p_MONT_ID] <= CONST_ONE_p_MONT_VAL;
      regs[CONST_R2_p_MONT_ID]  <= CONST_R2_p_MONT_VAL;
      regs[CONST_G_X_MONT_ID]   <= CONST_G_X_MONT_VAL;
      regs[CONST_G_Y_MONT_ID]   <= CONST_G_Y_MONT_VAL;
      regs[CONST_G_Z_MONT_ID]   <= CONST_G_Z_MONT_VAL;
      regs[CONST_R2_q_MONT_ID]  <= CONST_R2_q_MONT_VAL;
      regs[CONST_ONE_q_MONT_ID] <= CONST_ONE_q_MONT_VAL;
    end else begin
      // Host loads operands only between jobs
      if (host_wr && !busy) begin
        regs[host_wr_id] <= host_wr_data;
      end
      // Later assignment, controller wins
      if (rf_wr) begin
        regs[rf_wr_id] <= rf_wr_data;
      end
    end
  end

  assign host_rd_data = regs[host_rd_id];
  assign rf_rd_data   = regs[rf_rd_id];

  // Host and controller never target one register together
  assert property (@(posedge clka) disable iff (!rst_n)
    (rf_wr && host_wr) |-> (rf_wr_id != host_wr_id));

endmodule

/* logic/ecc_dsa_ctrl.sv */
`timescale 1ns/1ns

module ecc_dsa_ctrl (
  input  logic                     clka,
  input  logic                     rst_n,
  input  logic                     job_start,
  input  ecc_dsa_pkg::dsa_job_t    job,
  output logic                     busy,
  output logic                     done,
  output ecc_dsa_pkg::prog_addr_t  prog_addr,
  input  ecc_dsa_pkg::dsa_uop_t    uop,
  output ecc_dsa_pkg::reg_id_t     rf_rd_id,
  input  ecc_dsa_pkg::data_t       rf_rd_data,
  output logic                     rf_wr,
  output ecc_dsa_pkg::reg_id_t     rf_wr_id,
  output ecc_dsa_pkg::data_t       rf_wr_data,
  output logic                     core_wr,
  output ecc_dsa_pkg::opr_addr_t   core_wr_addr,
  output ecc_dsa_pkg::data_t       core_wr_data,
  output logic                     core_rd,
  output ecc_dsa_pkg::opr_addr_t   core_rd_addr,
  input  ecc_dsa_pkg::data_t       core_rd_data,
  output logic                     core_scalar_wr,
  output ecc_dsa_pkg::data_t       core_scalar,
  output logic                     core_cmd_valid,
  output ecc_dsa_pkg::dsa_opcode_t core_cmd,
  input  logic                     core_busy
);
  import ecc_dsa_pkg::*;

  ctrl_state_t state;
  prog_addr_t  pc;
  prog_addr_t  end_addr;
  prog_addr_t  job_s;
  prog_addr_t  job_e;
  logic        job_ok;
  reg_id_t     scalar_src;
  reg_id_t     rd_id;
  logic        wait_first;
  logic        exec;
  logic        is_cmd;
  logic        at_end;

  // --------------------------------------------------------------------------
  // Decode of the current micro-op
  // --------------------------------------------------------------------------
  assign exec = (state == EXEC);

  always_comb begin
    case (uop.opcode)
      DSA_UOP_KEYGEN,
      DSA_UOP_SIGN,
      DSA_UOP_VERIFY0,
      DSA_UOP_VERIFY1,
      DSA_UOP_VERIFY2: is_cmd = 1'b1;
      default:         is_cmd = 1'b0;
    endcase
  end

  // Only the closing NOP of the running program ends it
  assign at_end = (uop.opcode == DSA_UOP_NOP) && (pc == end_addr);

  // Program bounds for the requested job
  always_comb begin
    job_ok = 1'b1;
    job_s  = DSA_KG_S;
    job_e  = DSA_KG_E;
    case (job)
      JOB_SIGN: begin
        job_s = DSA_SGN_S;
        job_e = DSA_SGN_E;
      end
      JOB_VERIFY: begin
        job_s = DSA_VER_S;
        job_e = DSA_VER_E;
      end
      JOB_KEYGEN: job_ok = 1'b1;
      default:    job_ok = 1'b0;
    endcase
  end

  // Execute overlaps the fetch of the next word
  assign prog_addr = exec ? pc + 1'b1 : pc;

  assign busy = (state != IDLE);

  // --------------------------------------------------------------------------
  // Core and register bank strobes
  // --------------------------------------------------------------------------
  assign core_wr        = exec && (uop.opcode == DSA_UOP_WR_CORE);
  assign core_rd        = exec && (uop.opcode == DSA_UOP_RD_CORE);
  assign core_scalar_wr = exec && (uop.opcode == DSA_UOP_WR_SCALAR);
  assign core_cmd_valid = exec && is_cmd;
  assign core_wr_addr   = uop.opr_addr;
  assign core_rd_addr   = uop.opr_addr;
  assign core_cmd       = uop.opcode;

  // Scalar load reads the register picked by the latest FIXED_MSB
  assign rf_rd_id     = (uop.opcode == DSA_UOP_WR_SCALAR) ? scalar_src : uop.reg_id;
  assign core_wr_data = rf_rd_data;
  assign core_scalar  = rf_rd_data;

  // Read data lands one cycle after the strobe
  assign rf_wr      = (state == RD_CAPTURE);
  assign rf_wr_id   = rd_id;
  assign rf_wr_data = core_rd_data;

  always_ff @(posedge clka) begin
    if (exec && (uop.opcode == DSA_UOP_FIXED_MSB)) begin
      scalar_src <= uop.reg_id;
    end
    if (core_rd) begin
      rd_id <= uop.reg_id;
    end
  end

  // --------------------------------------------------------------------------
  // Fetch / execute FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clka) begin
    if (!rst_n) begin
      state      <= INIT_FETCH;
      pc         <= DSA_INIT_S;
      end_addr   <= DSA_INIT_E;
      wait_first <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        INIT_FETCH,
        FETCH: state <= EXEC;
        IDLE: begin
          if (job_start && job_ok) begin
            pc       <= job_s;
            end_addr <= job_e;
            state    <= FETCH;
          end
        end
        EXEC: begin
          if (at_end) begin
            state <= IDLE;
            done  <= 1'b1;
          end else begin
            pc <= pc + 1'b1;
            if (uop.opcode == DSA_UOP_RD_CORE) begin
              state <= RD_CAPTURE;
            end else if (is_cmd) begin
              state      <= WAIT_CORE;
              wait_first <= 1'b1;
            end
          end
        end
        RD_CAPTURE: state <= FETCH;
        WAIT_CORE: begin
          // core_busy may only rise the cycle after the command
          wait_first <= 1'b0;
          if (!wait_first && !core_busy) begin
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operand traffic stalls while the core is busy
  assert property (@(posedge clka) disable iff (!rst_n)
    core_busy |-> !(core_wr || core_rd || core_scalar_wr));

  // A new command never overlaps a running core operation
  assert property (@(posedge clka) disable iff (!rst_n)
    core_cmd_valid |-> !core_busy);

endmodule

/* logic/ecc_dsa_sequencer.sv */
`timescale 1ns/1ns

module ecc_dsa_sequencer (
  input  logic                    clka,
  input  ecc_dsa_pkg::prog_addr_t prog_addr,
  output ecc_dsa_pkg::dsa_uop_t   uop
);
  import ecc_dsa_pkg::*;

  // --------------------------------------------------------------------------
  // Micro-op ROM, one cycle from address to word
  // --------------------------------------------------------------------------
  always_ff @(posedge clka) begin
    case (prog_addr)
      // Core init, constants into operand memory
      DSA_INIT_S     : uop <= '{DSA_UOP_NOP,     NOP_ID,              UOP_OPR_DONTCARE};
      DSA_INIT_S + 1 : uop <= '{DSA_UOP_WR_CORE, CONST_ZERO_ID,       UOP_OPR_CONST_ZERO};
      DSA_INIT_S + 2 : uop <= '{DSA_UOP_WR_CORE, CONST_ONE_ID,        UOP_OPR_CONST_ONE};
      DSA_INIT_S + 3 : uop <= '{DSA_UOP_WR_CORE, CONST_E_a_MONT_ID,   UOP_OPR_CONST_E_a};
      DSA_INIT_S + 4 : uop <= '{DSA_UOP_WR_CORE, CONST_ONE_p_MONT_ID, UOP_OPR_CONST_ONE_MONT};
      DSA_INIT_S + 5 : uop <= '{DSA_UOP_WR_CORE, CONST_R2_p_MONT_ID,  UOP_OPR_CONST_R2_p};
      DSA_INIT_S + 6 : uop <= '{DSA_UOP_WR_CORE, CONST_G_X_MONT_ID,   UOP_OPR_CONST_GX_MONT};
      DSA_INIT_S + 7 : uop <= '{DSA_UOP_WR_CORE, CONST_G_Y_MONT_ID,   UOP_OPR_CONST_GY_MONT};
      DSA_INIT_S + 8 : uop <= '{DSA_UOP_WR_CORE, CONST_G_Z_MONT_ID,   UOP_OPR_CONST_GZ_MONT};
      DSA_INIT_S + 9 : uop <= '{DSA_UOP_WR_CORE, CONST_R2_q_MONT_ID,  UOP_OPR_CONST_R2_q};
      DSA_INIT_S + 10: uop <= '{DSA_UOP_WR_CORE, CONST_ONE_q_MONT_ID, UOP_OPR_CONST_ONE_q_MONT};
      DSA_INIT_E     : uop <= '{DSA_UOP_NOP,     NOP_ID,              UOP_OPR_DONTCARE};

      // Key generation
      DSA_KG_S       : uop <= '{DSA_UOP_FIXED_MSB, SCALAR_G_ID, UOP_OPR_DONTCARE};
      DSA_KG_S + 1   : uop <= '{DSA_UOP_WR_SCALAR, SCALAR_ID,   UOP_OPR_DONTCARE};
      DSA_KG_S + 2   : uop <= '{DSA_UOP_KEYGEN,    NOP_ID,      UOP_OPR_DONTCARE};
      DSA_KG_S + 3   : uop <= '{DSA_UOP_NOP,       NOP_ID,      UOP_OPR_DONTCARE};
      DSA_KG_S + 4   : uop <= '{DSA_UOP_RD_CORE,   PUBKEYX_ID,  UOP_OPR_Qx_AFFN};
      DSA_KG_S + 5   : uop <= '{DSA_UOP_RD_CORE,   PUBKEYY_ID,  UOP_OPR_Qy_AFFN};
      DSA_KG_E       : uop <= '{DSA_UOP_NOP,       NOP_ID,      UOP_OPR_DONTCARE};

      // Signing
      DSA_SGN_S      : uop <= '{DSA_UOP_WR_CORE,   MSG_ID,      UOP_OPR_HASH_MSG};
      DSA_SGN_S + 1  : uop <= '{DSA_UOP_WR_CORE,   PRIVKEY_ID,  UOP_OPR_PRIVKEY};
      DSA_SGN_S + 2  : uop <= '{DSA_UOP_WR_CORE,   SCALAR_G_ID, UOP_OPR_SCALAR_G};
      DSA_SGN_S + 3  : uop <= '{DSA_UOP_FIXED_MSB, SCALAR_G_ID, UOP_OPR_DONTCARE};
      DSA_SGN_S + 4  : uop <= '{DSA_UOP_WR_SCALAR, SCALAR_ID,   UOP_OPR_DONTCARE};
      DSA_SGN_S + 5  : uop <= '{DSA_UOP_SIGN,      NOP_ID,      UOP_OPR_DONTCARE};
      DSA_SGN_S + 6  : uop <= '{DSA_UOP_NOP,       NOP_ID,      UOP_OPR_DONTCARE};
      DSA_SGN_S + 7  : uop <= '{DSA_UOP_RD_CORE,   R_ID,        UOP_OPR_SIGN_R};
      DSA_SGN_S + 8  : uop <= '{DSA_UOP_RD_CORE,   S_ID,        UOP_OPR_SIGN_S};
      DSA_SGN_E      : uop <= '{DSA_UOP_NOP,       NOP_ID,      UOP_OPR_DONTCARE};

      // Verification in three core passes
      DSA_VER_S      : uop <= '{DSA_UOP_WR_CORE,   MSG_ID,       UOP_OPR_HASH_MSG};
      DSA_VER_S + 1  : uop <= '{DSA_UOP_WR_CORE,   R_ID,         UOP_OPR_SIGN_R};
      DSA_VER_S + 2  : uop <= '{DSA_UOP_WR_CORE,   S_ID,         UOP_OPR_SIGN_S};
      DSA_VER_S + 3  : uop <= '{DSA_UOP_VERIFY0,   NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 4  : uop <= '{DSA_UOP_NOP,       NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 5  : uop <= '{DSA_UOP_RD_CORE,   SCALAR_G_ID,  UOP_OPR_SCALAR_G};
      DSA_VER_S + 6  : uop <= '{DSA_UOP_RD_CORE,   SCALAR_PK_ID, UOP_OPR_SCALAR_PK};
      DSA_VER_S + 7  : uop <= '{DSA_UOP_FIXED_MSB, SCALAR_G_ID,  UOP_OPR_DONTCARE};
      DSA_VER_S + 8  : uop <= '{DSA_UOP_WR_SCALAR, SCALAR_ID,    UOP_OPR_DONTCARE};
      DSA_VER_S + 9  : uop <= '{DSA_UOP_VERIFY1,   NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 10 : uop <= '{DSA_UOP_NOP,       NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 11 : uop <= '{DSA_UOP_WR_CORE,   PUBKEYX_ID,   UOP_OPR_Qx_AFFN};
      DSA_VER_S + 12 : uop <= '{DSA_UOP_WR_CORE,   PUBKEYY_ID,   UOP_OPR_Qy_AFFN};
      DSA_VER_S + 13 : uop <= '{DSA_UOP_FIXED_MSB, SCALAR_PK_ID, UOP_OPR_DONTCARE};
      DSA_VER_S + 14 : uop <= '{DSA_UOP_WR_SCALAR, SCALAR_ID,    UOP_OPR_DONTCARE};
      DSA_VER_S + 15 : uop <= '{DSA_UOP_VERIFY2,   NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 16 : uop <= '{DSA_UOP_NOP,       NOP_ID,       UOP_OPR_DONTCARE};
      DSA_VER_S + 17 : uop <= '{DSA_UOP_RD_CORE,   R_VERIFY_ID,  UOP_OPR_Qx_AFFN};
      DSA_VER_E      : uop <= '{DSA_UOP_NOP,       NOP_ID,       UOP_OPR_DONTCARE};

      default        : uop <= '{DSA_UOP_NOP,       NOP_ID,       UOP_OPR_DONTCARE};
    endcase
  end

  // Once the controller has come out of reset the address stays defined
  assert property (@(posedge clka)
    !$isunknown($past(prog_addr)) |-> !$isunknown(prog_addr));

endmodule

/* logic/ecc_dsa_pkg.sv */
package ecc_dsa_pkg;

  // --------------------------------------------------------------------------
  // Widths and their types
  // --------------------------------------------------------------------------
  localparam int PROG_ADDR_W = 8;
  localparam int DATA_W      = 32;
  localparam int OPCODE_W    = 6;
  localparam int REG_ID_W    = 6;
  localparam int OPR_ADDR_W  = 8;
  localparam int NUM_REGS    = 2 ** REG_ID_W;

  typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [OPCODE_W-1:0]    dsa_opcode_t;
  typedef logic [REG_ID_W-1:0]    reg_id_t;
  typedef logic [OPR_ADDR_W-1:0]  opr_addr_t;
  typedef logic [1:0]             dsa_job_t;

  // --------------------------------------------------------------------------
  // Micro-op opcodes
  // --------------------------------------------------------------------------
  localparam dsa_opcode_t DSA_UOP_NOP       = 6'd0;
  localparam dsa_opcode_t DSA_UOP_WR_CORE   = 6'd1;
  localparam dsa_opcode_t DSA_UOP_RD_CORE   = 6'd2;
  localparam dsa_opcode_t DSA_UOP_WR_SCALAR = 6'd3;
  localparam dsa_opcode_t DSA_UOP_FIXED_MSB = 6'd4;
  // Commands handed to the point-multiplication core
  localparam dsa_opcode_t DSA_UOP_KEYGEN    = 6'd8;
  localparam dsa_opcode_t DSA_UOP_SIGN      = 6'd9;
  localparam dsa_opcode_t DSA_UOP_VERIFY0   = 6'd10;
  localparam dsa_opcode_t DSA_UOP_VERIFY1   = 6'd11;
  localparam dsa_opcode_t DSA_UOP_VERIFY2   = 6'd12;

  // Register bank indices
  localparam reg_id_t NOP_ID              = 6'd0;
  localparam reg_id_t CONST_ZERO_ID       = 6'd1;
  localparam reg_id_t CONST_ONE_ID        = 6'd2;
  localparam reg_id_t CONST_E_a_MONT_ID   = 6'd3;
  localparam reg_id_t CONST_ONE_p_MONT_ID = 6'd4;
  localparam reg_id_t CONST_R2_p_MONT_ID  = 6'd5;
  localparam reg_id_t CONST_G_X_MONT_ID   = 6'd6;
  localparam reg_id_t CONST_G_Y_MONT_ID   = 6'd7;
  localparam reg_id_t CONST_G_Z_MONT_ID   = 6'd8;
  localparam reg_id_t CONST_R2_q_MONT_ID  = 6'd9;
  localparam reg_id_t CONST_ONE_q_MONT_ID = 6'd10;
  localparam reg_id_t MSG_ID              = 6'd16;
  localparam reg_id_t PRIVKEY_ID          = 6'd17;
  localparam reg_id_t PUBKEYX_ID          = 6'd18;
  localparam reg_id_t PUBKEYY_ID          = 6'd19;
  localparam reg_id_t R_ID                = 6'd20;
  localparam reg_id_t S_ID                = 6'd21;
  localparam reg_id_t SCALAR_G_ID         = 6'd22;
  localparam reg_id_t SCALAR_PK_ID        = 6'd23;
  localparam reg_id_t SCALAR_ID           = 6'd24;
  localparam reg_id_t R_VERIFY_ID         = 6'd25;

  // Core operand memory map
  localparam opr_addr_t UOP_OPR_DONTCARE        = 8'hff;
  localparam opr_addr_t UOP_OPR_CONST_ZERO      = 8'h01;
  localparam opr_addr_t UOP_OPR_CONST_ONE       = 8'h02;
  localparam opr_addr_t UOP_OPR_CONST_E_a       = 8'h03;
  localparam opr_addr_t UOP_OPR_CONST_ONE_MONT  = 8'h04;
  localparam opr_addr_t UOP_OPR_CONST_R2_p      = 8'h05;
  localparam opr_addr_t UOP_OPR_CONST_GX_MONT   = 8'h06;
  localparam opr_addr_t UOP_OPR_CONST_GY_MONT   = 8'h07;
  localparam opr_addr_t UOP_OPR_CONST_GZ_MONT   = 8'h08;
  localparam opr_addr_t UOP_OPR_CONST_R2_q      = 8'h09;
  localparam opr_addr_t UOP_OPR_CONST_ONE_q_MONT = 8'h0a;
  localparam opr_addr_t UOP_OPR_HASH_MSG        = 8'h10;
  localparam opr_addr_t UOP_OPR_PRIVKEY         = 8'h11;
  localparam opr_addr_t UOP_OPR_SCALAR_G        = 8'h12;
  localparam opr_addr_t UOP_OPR_SCALAR_PK       = 8'h13;
  localparam opr_addr_t UOP_OPR_SIGN_R          = 8'h14;
  localparam opr_addr_t UOP_OPR_SIGN_S          = 8'h15;
  localparam opr_addr_t UOP_OPR_Qx_AFFN         = 8'h20;
  localparam opr_addr_t UOP_OPR_Qy_AFFN         = 8'h21;

  // ROM word
  typedef struct packed {
    dsa_opcode_t opcode;
    reg_id_t     reg_id;
    opr_addr_t   opr_addr;
  } dsa_uop_t;

  localparam dsa_job_t JOB_KEYGEN = 2'd0;
  localparam dsa_job_t JOB_SIGN   = 2'd1;
  localparam dsa_job_t JOB_VERIFY = 2'd2;

  // Program bounds, each end is a closing NOP
  localparam prog_addr_t DSA_INIT_S = 8'd0;
  localparam prog_addr_t DSA_INIT_E = 8'd11;
  localparam prog_addr_t DSA_KG_S   = 8'd16;
  localparam prog_addr_t DSA_KG_E   = 8'd22;
  localparam prog_addr_t DSA_SGN_S  = 8'd32;
  localparam prog_addr_t DSA_SGN_E  = 8'd41;
  localparam prog_addr_t DSA_VER_S  = 8'd48;
  localparam prog_addr_t DSA_VER_E  = 8'd66;

  // Stand-in curve constants
  localparam data_t CONST_ZERO_VAL       = 32'h0000_0000;
  localparam data_t CONST_ONE_VAL        = 32'h0000_0001;
  localparam data_t CONST_E_a_MONT_VAL   = 32'h3c1f_a8d2;
  localparam data_t CONST_ONE_p_MONT_VAL = 32'h0000_0100;
  localparam data_t CONST_R2_p_MONT_VAL  = 32'h0001_0000;
  localparam data_t CONST_G_X_MONT_VAL   = 32'haa87_ca22;
  localparam data_t CONST_G_Y_MONT_VAL   = 32'h3617_de4a;
  localparam data_t CONST_G_Z_MONT_VAL   = 32'h0000_0101;
  localparam data_t CONST_R2_q_MONT_VAL  = 32'h0002_0001;
  localparam data_t CONST_ONE_q_MONT_VAL = 32'h0000_0200;

  typedef enum logic [2:0] {
    INIT_FETCH,
    IDLE,
    FETCH,
    EXEC,
    RD_CAPTURE,
    WAIT_CORE
  } ctrl_state_t;

endpackage
